// File: bench/tb_hdr_insert.sv
`timescale 1ns/10ps

module tb_hdr_insert;

    import hdr_insert_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int N_ROWS = 20;

    typedef struct packed {
        keep_t      hdr_keep;
        data_word_t hdr_data;
        int         n_beats;
        keep_t      last_keep;
        bit         gap_en;
        bit         bp_en;
    } row_t;

    logic         clk;
    logic         rst_n;
    logic         i_in_valid;
    stream_beat_t i_in_beat;
    logic         o_in_ready;
    logic         i_hdr_valid;
    header_beat_t i_hdr_beat;
    logic         o_hdr_ready;
    logic         o_out_valid;
    stream_beat_t o_out_beat;
    logic         i_out_ready;

    row_t         rows [N_ROWS];
    stream_beat_t in_q [$];
    stream_beat_t exp_q [$];
    logic [7:0]   byte_cnt;
    integer       seed;

    hdr_insert_top hdr_insert_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (i_in_valid),
        .i_in_beat   (i_in_beat),
        .o_in_ready  (o_in_ready),
        .i_hdr_valid (i_hdr_valid),
        .i_hdr_beat  (i_hdr_beat),
        .o_hdr_ready (o_hdr_ready),
        .o_out_valid (o_out_valid),
        .o_out_beat  (o_out_beat),
        .i_out_ready (i_out_ready)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic report_timeout(input string port);
        $display("timeout: the %s port made no progress in %0d cycles", port, TIMEOUT);
        abort_run();
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // bytes outside the expected keep are don't care
    task automatic check_beat(input string name, input stream_beat_t exp,
                              input stream_beat_t act);
        data_word_t mask;
        for (int b = 0; b < STREAM_BYTES; b++) begin
            mask[b*BYTE_W +: BYTE_W] = {BYTE_W{exp.keep[b]}};
        end
        if ((exp.data & mask) !== (act.data & mask) || exp.keep !== act.keep
                || exp.last !== act.last) begin
            $display("[FAIL] %0t %s data/keep/last expected %h/%b/%b got %h/%b/%b", $time,
                     name, exp.data & mask, exp.keep, exp.last, act.data, act.keep, act.last);
            abort_run();
        end
    endtask

    // input beats plus the expected output beats of one frame
    task automatic build_row(input row_t row);
        logic [7:0]   bytes [$];
        stream_beat_t beat;
        int           hc;
        int           n;
        hc = int'(keep_to_count(row.hdr_keep));
        for (int i = hc - 1; i >= 0; i--) begin
            bytes.push_back(row.hdr_data[i*BYTE_W +: BYTE_W]);
        end
        for (int b = 0; b < row.n_beats; b++) begin
            beat      = '0;
            beat.last = (b == row.n_beats - 1);
            beat.keep = beat.last ? row.last_keep : '1;
            n         = int'(keep_to_count(beat.keep));
            for (int i = 0; i < n; i++) begin
                beat.data[(STREAM_BYTES-1-i)*BYTE_W +: BYTE_W] = byte_cnt;
                bytes.push_back(byte_cnt);
                byte_cnt = byte_cnt + 8'd1;
            end
            in_q.push_back(beat);
        end
        beat = '0;
        for (int i = 0; i < bytes.size(); i++) begin
            beat.data[(STREAM_BYTES-1-i%STREAM_BYTES)*BYTE_W +: BYTE_W] = bytes[i];
            beat.keep[STREAM_BYTES-1-i%STREAM_BYTES] = 1'b1;
            if (i % STREAM_BYTES == STREAM_BYTES - 1 || i == bytes.size() - 1) begin
                beat.last = (i == bytes.size() - 1);
                exp_q.push_back(beat);
                beat = '0;
            end
        end
    endtask

    // headers run ahead of their frames
    task automatic drive_headers();
        int to;
        foreach (rows[r]) begin
            i_hdr_valid     <= 1'b1;
            i_hdr_beat.data <= rows[r].hdr_data;
            i_hdr_beat.keep <= rows[r].hdr_keep;
            to = 0;
            do begin
                @(posedge clk);
                to++;
                if (to > TIMEOUT) report_timeout("header input");
            end while (!o_hdr_ready);
        end
        i_hdr_valid <= 1'b0;
    endtask

    task automatic drive_frames();
        int to;
        foreach (rows[r]) begin
            for (int b = 0; b < rows[r].n_beats; b++) begin
                while (rows[r].gap_en && ($random(seed) & 3) == 0) begin
                    i_in_valid <= 1'b0;
                    @(posedge clk);
                end
                i_in_valid <= 1'b1;
                i_in_beat  <= in_q.pop_front();
                to = 0;
                do begin
                    @(posedge clk);
                    to++;
                    if (to > TIMEOUT) report_timeout("frame input");
                end while (!o_in_ready);
            end
        end
        i_in_valid <= 1'b0;
    endtask

    task automatic watch_output();
        stream_beat_t held;
        stream_beat_t exp;
        logic         held_valid;
        int           idle;
        int           r;
        held_valid = 1'b0;
        idle       = 0;
        r          = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            // a stalled beat must stay put
            if (held_valid) begin
                check_flag("o_out_valid", 1'b1, o_out_valid);
                check_beat("o_out_beat", held, o_out_beat);
            end
            held_valid = o_out_valid && !i_out_ready;
            held       = o_out_beat;
            if (o_out_valid && i_out_ready) begin
                exp = exp_q.pop_front();
                check_beat("o_out_beat", exp, o_out_beat);
                if (exp.last) r++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) report_timeout("output");
            end
            if (r < N_ROWS && rows[r].bp_en) begin
                i_out_ready <= ($random(seed) & 1) != 0;
            end else begin
                i_out_ready <= 1'b1;
            end
        end
    endtask

    initial begin
        // hdr keep, hdr data, beats, last keep, gaps, back-pressure
        rows = '{
            '{4'b0001, 32'hc0c1c2c3, 3, 4'b1000, 1'b0, 1'b0},
            '{4'b0011, 32'hc4c5c6c7, 2, 4'b1100, 1'b0, 1'b0},
            '{4'b0111, 32'hc8c9cacb, 4, 4'b1110, 1'b0, 1'b0},
            '{4'b1111, 32'hcccdcecf, 3, 4'b1111, 1'b0, 1'b0},
            '{4'b0000, 32'hd0d1d2d3, 3, 4'b1000, 1'b0, 1'b0},
            '{4'b0000, 32'hd4d5d6d7, 2, 4'b1100, 1'b0, 1'b0},
            '{4'b0000, 32'hd8d9dadb, 1, 4'b1110, 1'b0, 1'b0},
            '{4'b0000, 32'hdcdddedf, 4, 4'b1111, 1'b0, 1'b0},
            '{4'b0001, 32'he0e1e2e3, 1, 4'b1100, 1'b1, 1'b0},
            '{4'b0001, 32'he4e5e6e7, 2, 4'b1110, 1'b0, 1'b1},
            '{4'b0001, 32'he8e9eaeb, 1, 4'b1111, 1'b1, 1'b1},
            '{4'b0011, 32'heceeeeef, 3, 4'b1000, 1'b1, 1'b0},
            '{4'b0011, 32'hf0f1f2f3, 1, 4'b1110, 1'b0, 1'b1},
            '{4'b0011, 32'hf4f5f6f7, 2, 4'b1111, 1'b1, 1'b1},
            '{4'b0111, 32'hf8f9fafb, 1, 4'b1000, 1'b1, 1'b0},
            '{4'b0111, 32'hfcfdfeff, 2, 4'b1100, 1'b0, 1'b1},
            '{4'b0111, 32'hb0b1b2b3, 3, 4'b1111, 1'b1, 1'b1},
            '{4'b1111, 32'hb4b5b6b7, 2, 4'b1000, 1'b1, 1'b1},
            '{4'b1111, 32'hb8b9babb, 1, 4'b1100, 1'b0, 1'b1},
            '{4'b1111, 32'hbcbdbebf, 4, 4'b1110, 1'b1, 1'b1}
        };
        seed        = 32'h45da;
        clk         = 1'b0;
        rst_n       = 1'b0;
        i_in_valid  = 1'b0;
        i_in_beat   = '0;
        i_hdr_valid = 1'b0;
        i_hdr_beat  = '0;
        i_out_ready = 1'b1;
        byte_cnt    = 8'h00;
        foreach (rows[r]) build_row(rows[r]);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("o_out_valid", 1'b0, o_out_valid);
        check_flag("o_in_ready", 1'b1, o_in_ready);
        check_flag("o_hdr_ready", 1'b1, o_hdr_ready);
        fork
            drive_headers();
            drive_frames();
            watch_output();
        join
        // nothing may follow the final expected beat
        i_out_ready <= 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            check_flag("o_out_valid", 1'b0, o_out_valid);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run by its log
rm -rf obj_dir sim.log
verilator --binary -f vlog.f --top-module tb_hdr_insert -o tb_hdr_insert \
    && ./obj_dir/tb_hdr_insert > sim.log 2>&1 \
    || echo "build or simulation returned an error"
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "result: pass" && exit 0 \
    || { echo "result: fail, see sim.log"; exit 1; }

// File: verilog/byte_packer.sv
`timescale 1ns/10ps

module byte_packer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_valid,
    input  hdr_insert_pkg::tagged_beat_t i_tagged,
    output logic                         o_ready,
    output logic                         o_valid,
    output hdr_insert_pkg::stream_beat_t o_beat,
    input  logic                         i_ready
);

    import hdr_insert_pkg::*;

    localparam int WORD_W = STREAM_BYTES * BYTE_W;

    logic                out_valid;
    stream_beat_t        out_beat;
    logic                spill_pending;
    data_word_t          res_data;
    byte_count_t         res_cnt;

    byte_count_t         hdr_cnt;
    byte_count_t         in_cnt;
    byte_count_t         cur_cnt;
    byte_count_t         total_cnt;
    data_word_t          hdr_aligned;
    data_word_t          in_data;
    data_word_t          cur_data;
    logic [2*WORD_W-1:0] window;
    logic                spills;
    logic                in_fire;
    logic                out_fire;
    logic                spill_fire;

    assign o_valid = out_valid;
    assign o_beat  = out_beat;

    // no new beat while the spill beat is still owed
    assign o_ready    = (!out_valid || i_ready) && !spill_pending;
    assign in_fire    = i_valid && o_ready;
    assign out_fire   = out_valid && i_ready;
    assign spill_fire = spill_pending && out_fire;

    always_comb begin
        hdr_cnt = keep_to_count(i_tagged.hdr.keep);
        in_cnt  = keep_to_count(i_tagged.beat.keep);

        // header bytes moved from the low end to the top
        hdr_aligned = i_tagged.hdr.data << ((STREAM_BYTES - int'(hdr_cnt)) * BYTE_W);

        // zero the unused bytes so the residue stays clean
        for (int b = 0; b < STREAM_BYTES; b++) begin
            if (i_tagged.beat.keep[b]) begin
                in_data[b*BYTE_W +: BYTE_W] = i_tagged.beat.data[b*BYTE_W +: BYTE_W];
            end else begin
                in_data[b*BYTE_W +: BYTE_W] = '0;
            end
        end

        if (i_tagged.first) begin
            cur_data = hdr_aligned;
            cur_cnt  = hdr_cnt;
        end else begin
            cur_data = res_data;
            cur_cnt  = res_cnt;
        end

        // residue on top, incoming bytes right behind it
        window = {cur_data, {WORD_W{1'b0}}}
               | ({in_data, {WORD_W{1'b0}}} >> (int'(cur_cnt) * BYTE_W));

        total_cnt = cur_cnt + in_cnt;
        spills    = i_tagged.beat.last && (total_cnt > byte_count_t'(STREAM_BYTES));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid     <= 1'b0;
            spill_pending <= 1'b0;
            res_cnt       <= '0;
        end else if (in_fire) begin
            out_valid     <= 1'b1;
            spill_pending <= spills;
            if (i_tagged.beat.last && !spills) begin
                res_cnt <= '0;
            end else begin
                res_cnt <= total_cnt - byte_count_t'(STREAM_BYTES);
            end
        end else if (spill_fire) begin
            out_valid     <= 1'b1;
            spill_pending <= 1'b0;
            res_cnt       <= '0;
        end else if (out_fire) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            res_data      <= window[WORD_W-1:0];
            out_beat.data <= window[2*WORD_W-1 -: WORD_W];
            out_beat.keep <= count_to_keep(total_cnt);
            out_beat.last <= i_tagged.beat.last && !spills;
        end else if (spill_fire) begin
            // leftover bytes of the frame end
            out_beat.data <= res_data;
            out_beat.keep <= count_to_keep(res_cnt);
            out_beat.last <= 1'b1;
        end
    end

endmodule

// File: verilog/frame_gate.sv
`timescale 1ns/10ps

module frame_gate (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_in_valid,
    input  hdr_insert_pkg::stream_beat_t i_in_beat,
    output logic                         o_in_ready,
    input  logic                         i_hdr_valid,
    input  hdr_insert_pkg::header_beat_t i_hdr_beat,
    output logic                         o_hdr_ready,
    output logic                         o_valid,
    output hdr_insert_pkg::tagged_beat_t o_tagged,
    input  logic                         i_ready
);

    logic in_frame;
    logic hdr_ok;
    logic fire;

    // a first beat needs its header alongside
    assign hdr_ok = in_frame || i_hdr_valid;

    assign o_valid     = i_in_valid && hdr_ok;
    assign o_in_ready  = i_ready && hdr_ok;
    assign o_hdr_ready = i_ready && i_in_valid && !in_frame;

    assign fire = o_valid && i_ready;

    always_comb begin
        o_tagged.beat  = i_in_beat;
        o_tagged.first = !in_frame;
        if (in_frame) begin
            o_tagged.hdr = '0;
        end else begin
            o_tagged.hdr = i_hdr_beat;
        end
    end

    // single beat frames leave in_frame clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame <= 1'b0;
        end else if (fire) begin
            in_frame <= !i_in_beat.last;
        end
    end

endmodule

// File: verilog/hdr_insert_pkg.sv
package hdr_insert_pkg;

    localparam int STREAM_BYTES = 4;
    localparam int BYTE_W = 8;

    typedef logic [STREAM_BYTES*BYTE_W-1:0] data_word_t;
    typedef logic [STREAM_BYTES-1:0] keep_t;

    // 0 .. 2*STREAM_BYTES bytes
    typedef logic [$clog2(2*STREAM_BYTES+1)-1:0] byte_count_t;

    typedef struct packed {
        data_word_t data;
        keep_t      keep;
        logic       last;
    } stream_beat_t;

    // valid header bytes sit in the low positions
    typedef struct packed {
        data_word_t data;
        keep_t      keep;
    } header_beat_t;

    typedef struct packed {
        stream_beat_t beat;
        header_beat_t hdr;
        logic         first;
    } tagged_beat_t;

    function automatic byte_count_t keep_to_count(input keep_t keep);
        byte_count_t cnt;
        cnt = '0;
        for (int b = 0; b < STREAM_BYTES; b++) begin
            cnt = cnt + byte_count_t'(keep[b]);
        end
        return cnt;
    endfunction

    // left-aligned keep for a byte count, saturating at a full beat
    function automatic keep_t count_to_keep(input byte_count_t cnt);
        keep_t keep;
        for (int b = 0; b < STREAM_BYTES; b++) begin
            keep[b] = int'(cnt) > (STREAM_BYTES - 1 - b);
        end
        return keep;
    endfunction

endpackage

// File: verilog/hdr_insert_top.sv
`timescale 1ns/10ps

module hdr_insert_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_in_valid,
    input  hdr_insert_pkg::stream_beat_t i_in_beat,
    output logic                         o_in_ready,
    input  logic                         i_hdr_valid,
    input  hdr_insert_pkg::header_beat_t i_hdr_beat,
    output logic                         o_hdr_ready,
    output logic                         o_out_valid,
    output hdr_insert_pkg::stream_beat_t o_out_beat,
    input  logic                         i_out_ready
);

    import hdr_insert_pkg::*;

    logic         in_s_valid;
    stream_beat_t in_s_beat;
    logic         in_s_ready;

    logic         hdr_s_valid;
    header_beat_t hdr_s_beat;
    logic         hdr_s_ready;

    logic         gate_valid;
    tagged_beat_t gate_tagged;
    logic         gate_ready;

    logic         mid_valid;
    tagged_beat_t mid_tagged;
    logic         mid_ready;

    stream_slice #(
        .T(stream_beat_t)
    ) in_slice_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_in_valid),
        .i_data  (i_in_beat),
        .o_ready (o_in_ready),
        .o_valid (in_s_valid),
        .o_data  (in_s_beat),
        .i_ready (in_s_ready)
    );

    stream_slice #(
        .T(header_beat_t)
    ) hdr_slice_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_hdr_valid),
        .i_data  (i_hdr_beat),
        .o_ready (o_hdr_ready),
        .o_valid (hdr_s_valid),
        .o_data  (hdr_s_beat),
        .i_ready (hdr_s_ready)
    );

    frame_gate frame_gate_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (in_s_valid),
        .i_in_beat   (in_s_beat),
        .o_in_ready  (in_s_ready),
        .i_hdr_valid (hdr_s_valid),
        .i_hdr_beat  (hdr_s_beat),
        .o_hdr_ready (hdr_s_ready),
        .o_valid     (gate_valid),
        .o_tagged    (gate_tagged),
        .i_ready     (gate_ready)
    );

    // breaks the comb path from gate to packer
    stream_slice #(
        .T(tagged_beat_t)
    ) mid_slice_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (gate_valid),
        .i_data  (gate_tagged),
        .o_ready (gate_ready),
        .o_valid (mid_valid),
        .o_data  (mid_tagged),
        .i_ready (mid_ready)
    );

    byte_packer byte_packer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (mid_valid),
        .i_tagged (mid_tagged),
        .o_ready  (mid_ready),
        .o_valid  (o_out_valid),
        .o_beat   (o_out_beat),
        .i_ready  (i_out_ready)
    );

endmodule

// File: verilog/stream_slice.sv
`timescale 1ns/10ps

module stream_slice #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst_n,
    input  logic i_valid,
    input  T     i_data,
    output logic o_ready,
    output logic o_valid,
    output T     o_data,
    input  logic i_ready
);

    logic main_valid;
    T     main_data;
    logic skid_valid;
    T     skid_data;
    logic in_fire;
    logic main_load;

    // ready only looks at the skid entry, so no comb path crosses the slice
    assign o_ready   = !skid_valid;
    assign in_fire   = i_valid && o_ready;
    assign main_load = !main_valid || i_ready;

    assign o_valid = main_valid;
    assign o_data  = main_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // drain skid first, otherwise take the new item directly
            main_valid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : i_data;
        end
        if (in_fire && !main_load) begin
            skid_data <= i_data;
        end
    end

endmodule

// File: vlog.f
verilog/hdr_insert_pkg.sv
verilog/stream_slice.sv
verilog/frame_gate.sv
verilog/byte_packer.sv
verilog/hdr_insert_top.sv
bench/tb_hdr_insert.sv
